// ==== hw/coreDefs.sv ====
package coreDefs;

    // Datapath and register index widths fixed by RV32I
    localparam int xlen = 32;
    localparam int regIdxBits = 5;

    // First instruction address
    localparam logic [xlen-1:0] resetVector = 32'h0000_1000;

    // addi x0, x0, 0
    localparam logic [xlen-1:0] nopInstr = 32'h0000_0013;

    // Branch conditions still decoded
    localparam logic [2:0] f3Beq = 3'b000;
    localparam logic [2:0] f3Bne = 3'b001;

    // ALU funct3 field
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll = 3'b001;
    localparam logic [2:0] f3Slt = 3'b010;
    localparam logic [2:0] f3Sltu = 3'b011;
    localparam logic [2:0] f3Xor = 3'b100;
    localparam logic [2:0] f3Shr = 3'b101;
    localparam logic [2:0] f3Or = 3'b110;
    localparam logic [2:0] f3And = 3'b111;

    // Instruction classes, anything else runs as a NOP
    typedef enum logic [6:0] {
        opReg = 7'b0110011,
        opImm = 7'b0010011,
        opLui = 7'b0110111,
        opLoad = 7'b0000011,
        opStore = 7'b0100011,
        opBranch = 7'b1100011
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
        aluSrl, aluSra, aluOr, aluAnd, aluPassB
    } aluOpT;

    // Source of an FD operand
    typedef enum logic [1:0] {
        fromReg, fromExec, fromMem, fromWb
    } fwdSelT;

    // Instruction writes a register other than x0
    function automatic logic writesReg(input logic [xlen-1:0] instr);
        logic isWriter;
        isWriter = (instr[6:0] == opReg) || (instr[6:0] == opImm) ||
                   (instr[6:0] == opLui) || (instr[6:0] == opLoad);
        return isWriter && (instr[11:7] != '0);
    endfunction

endpackage

// ==== hw/regFile.sv ====
`timescale 1ns/100ps

module regFile import coreDefs::*; (
    input  logic                  clk,
    input  logic [regIdxBits-1:0] rdIdxA,
    input  logic [regIdxBits-1:0] rdIdxB,
    input  logic [regIdxBits-1:0] wrIdx,
    input  logic [xlen-1:0]       wrData,
    input  logic                  wrEn,
    output logic [xlen-1:0]       rdDataA,
    output logic [xlen-1:0]       rdDataB
);

    // x1 to x31 only, x0 has no storage
    logic [xlen-1:0] regs [1:(2**regIdxBits)-1];

    // Write on the edge, writes to x0 dropped
    always_ff @(posedge clk) begin
        if (wrEn && (wrIdx != '0)) begin
            regs[wrIdx] <= wrData;
        end
    end

    // Asynchronous reads
    // Same-cycle write shows the old value, FD forwards the new one
    always_comb begin
        if (rdIdxA == '0) begin
            rdDataA = '0;
        end else begin
            rdDataA = regs[rdIdxA];
        end
        if (rdIdxB == '0) begin
            rdDataB = '0;
        end else begin
            rdDataB = regs[rdIdxB];
        end
    end

endmodule

// ==== hw/fetchDecode.sv ====
`timescale 1ns/100ps

module fetchDecode import coreDefs::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic [xlen-1:0]       icacheDout,
    input  logic                  flush,
    input  logic [xlen-1:0]       branchTarget,
    input  logic [xlen-1:0]       aluResultX,
    input  logic [xlen-1:0]       memForward,
    input  logic [xlen-1:0]       wbData,
    input  logic [xlen-1:0]       instrM,
    input  logic [regIdxBits-1:0] wbIdx,
    input  logic                  wbEn,
    input  logic [xlen-1:0]       rdDataA,
    input  logic [xlen-1:0]       rdDataB,
    output logic [regIdxBits-1:0] rdIdxA,
    output logic [regIdxBits-1:0] rdIdxB,
    output logic [xlen-1:0]       icacheAddr,
    output logic                  icacheRe,
    output logic [xlen-1:0]       instrX,
    output logic [xlen-1:0]       pcX,
    output logic [xlen-1:0]       immX,
    output logic [xlen-1:0]       opAX,
    output logic [xlen-1:0]       opBX
);

    // Address of the word now on icacheDout
    logic [xlen-1:0] pc;
    logic [xlen-1:0] nextPc;
    // Low until the first fetch after reset has returned
    logic fetchValid;
    logic [xlen-1:0] instrFd;
    logic [xlen-1:0] immFd;
    fwdSelT selA;
    fwdSelT selB;
    logic [xlen-1:0] opAFd;
    logic [xlen-1:0] opBFd;
    logic [xlen-1:0] opARegX;
    logic [xlen-1:0] opBRegX;
    // Operand was taken from a load still in X
    logic lateLoadA;
    logic lateLoadB;
    logic loadInX;

    // Youngest producer wins, x0 never forwarded
    function automatic fwdSelT pickSource(
        input logic [regIdxBits-1:0] src,
        input logic [xlen-1:0]       instrInX,
        input logic [xlen-1:0]       instrInM,
        input logic [regIdxBits-1:0] idxW,
        input logic                  enW
    );
        fwdSelT sel;
        sel = fromReg;
        if (src != '0) begin
            if (writesReg(instrInX) && (instrInX[11:7] == src)) begin
                sel = fromExec;
            end else if (writesReg(instrInM) && (instrInM[11:7] == src)) begin
                sel = fromMem;
            end else if (enW && (idxW == src)) begin
                sel = fromWb;
            end
        end
        return sel;
    endfunction

    // Fetch never idles, stall freezes the memory instead
    assign icacheRe = 1'b1;

    // Redirect shows on icacheAddr in the flush cycle
    assign nextPc = flush ? branchTarget : pc + 32'd4;
    assign icacheAddr = nextPc;

    assign instrFd = fetchValid ? icacheDout : nopInstr;
    assign rdIdxA = instrFd[19:15];
    assign rdIdxB = instrFd[24:20];
    assign loadInX = (instrX[6:0] == opLoad);

    // Immediate by format
    always_comb begin
        case (opcodeT'(instrFd[6:0]))
            opImm, opLoad: immFd = {{20{instrFd[31]}}, instrFd[31:20]};
            opStore: immFd = {{20{instrFd[31]}}, instrFd[31:25], instrFd[11:7]};
            opBranch: immFd = {{19{instrFd[31]}}, instrFd[31], instrFd[7],
                               instrFd[30:25], instrFd[11:8], 1'b0};
            opLui: immFd = {instrFd[31:12], 12'b0};
            default: immFd = '0;
        endcase
    end

    // Operand forwarding
    always_comb begin
        selA = pickSource(rdIdxA, instrX, instrM, wbIdx, wbEn);
        selB = pickSource(rdIdxB, instrX, instrM, wbIdx, wbEn);
        case (selA)
            fromExec: opAFd = aluResultX;
            fromMem: opAFd = memForward;
            fromWb: opAFd = wbData;
            default: opAFd = rdDataA;
        endcase
        case (selB)
            fromExec: opBFd = aluResultX;
            fromMem: opBFd = memForward;
            fromWb: opBFd = wbData;
            default: opBFd = rdDataB;
        endcase
    end

    // Load result lands one cycle late, patch it in while the consumer is in X
    assign opAX = lateLoadA ? memForward : opARegX;
    assign opBX = lateLoadB ? memForward : opBRegX;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetVector - 32'd4;
            fetchValid <= 1'b0;
            instrX <= nopInstr;
            pcX <= '0;
            immX <= '0;
            opARegX <= '0;
            opBRegX <= '0;
            lateLoadA <= 1'b0;
            lateLoadB <= 1'b0;
        end else if (!stall) begin
            pc <= nextPc;
            fetchValid <= 1'b1;
            pcX <= pc;
            immX <= immFd;
            opARegX <= opAFd;
            opBRegX <= opBFd;
            if (flush) begin
                // Squash the fall-through instruction
                instrX <= nopInstr;
                lateLoadA <= 1'b0;
                lateLoadB <= 1'b0;
            end else begin
                instrX <= instrFd;
                lateLoadA <= loadInX && (selA == fromExec);
                lateLoadB <= loadInX && (selB == fromExec);
            end
        end
    end

    // Sequential and redirected fetches stay word aligned
    assert property (@(posedge clk) disable iff (reset) icacheAddr[1:0] == 2'b00)
        else $error("icacheAddr not word aligned");

endmodule

// ==== hw/executeStage.sv ====
`timescale 1ns/100ps

module executeStage import coreDefs::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic [xlen-1:0] instrX,
    input  logic [xlen-1:0] pcX,
    input  logic [xlen-1:0] immX,
    input  logic [xlen-1:0] opAX,
    input  logic [xlen-1:0] opBX,
    output logic [xlen-1:0] aluResultX,
    output logic            flush,
    output logic [xlen-1:0] branchTarget,
    output logic [xlen-1:0] dcacheAddr,
    output logic [3:0]      dcacheWe,
    output logic            dcacheRe,
    output logic [xlen-1:0] dcacheDin,
    output logic [xlen-1:0] instrM,
    output logic [xlen-1:0] aluResultM,
    output logic            loadPendingM
);

    opcodeT opcode;
    logic [2:0] funct3;
    // instr[30] picks sub and sra
    logic altBit;
    aluOpT aluOp;
    logic useImm;
    logic [xlen-1:0] aluB;
    logic [4:0] shamt;
    logic isLoad;
    logic isStore;

    // Shared funct3 decode for register and immediate forms
    function automatic aluOpT aluFromFunct(
        input logic [2:0] f3,
        input logic       alt,
        input logic       isReg
    );
        aluOpT op;
        case (f3)
            f3AddSub: op = (isReg && alt) ? aluSub : aluAdd;
            f3Sll: op = aluSll;
            f3Slt: op = aluSlt;
            f3Sltu: op = aluSltu;
            f3Xor: op = aluXor;
            f3Shr: op = alt ? aluSra : aluSrl;
            f3Or: op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    assign opcode = opcodeT'(instrX[6:0]);
    assign funct3 = instrX[14:12];
    assign altBit = instrX[30];
    assign isLoad = (opcode == opLoad);
    assign isStore = (opcode == opStore);

    // Loads, stores and unknown opcodes fall back to add with immediate
    always_comb begin
        aluOp = aluAdd;
        useImm = 1'b1;
        case (opcode)
            opReg: begin
                aluOp = aluFromFunct(funct3, altBit, 1'b1);
                useImm = 1'b0;
            end
            opImm: aluOp = aluFromFunct(funct3, altBit, 1'b0);
            opLui: aluOp = aluPassB;
            default: ;
        endcase
    end

    assign aluB = useImm ? immX : opBX;
    assign shamt = aluB[4:0];

    always_comb begin
        case (aluOp)
            aluSub: aluResultX = opAX - aluB;
            aluSll: aluResultX = opAX << shamt;
            aluSlt: aluResultX = {{(xlen-1){1'b0}}, $signed(opAX) < $signed(aluB)};
            aluSltu: aluResultX = {{(xlen-1){1'b0}}, opAX < aluB};
            aluXor: aluResultX = opAX ^ aluB;
            aluSrl: aluResultX = opAX >> shamt;
            aluSra: aluResultX = $signed(opAX) >>> shamt;
            aluOr: aluResultX = opAX | aluB;
            aluAnd: aluResultX = opAX & aluB;
            aluPassB: aluResultX = aluB;
            default: aluResultX = opAX + aluB;
        endcase
    end

    // Only BEQ and BNE can be taken
    assign flush = (opcode == opBranch) &&
                   (((funct3 == f3Beq) && (opAX == opBX)) ||
                    ((funct3 == f3Bne) && (opAX != opBX)));
    assign branchTarget = pcX + immX;

    // Word access at the ALU sum
    assign dcacheAddr = aluResultX;
    assign dcacheRe = isLoad;
    assign dcacheWe = {4{isStore}};
    assign dcacheDin = opBX;

    always_ff @(posedge clk) begin
        if (reset) begin
            instrM <= nopInstr;
            loadPendingM <= 1'b0;
        end else if (!stall) begin
            instrM <= instrX;
            loadPendingM <= isLoad;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            aluResultM <= aluResultX;
        end
    end

    // Taken branch leaves a NOP behind it in X
    assert property (@(posedge clk) disable iff (reset)
        (flush && !stall) |=> (instrX == nopInstr))
        else $error("fall-through instruction not squashed after flush");

endmodule

// ==== hw/memWriteback.sv ====
`timescale 1ns/100ps

module memWriteback import coreDefs::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic [xlen-1:0]       instrM,
    input  logic [xlen-1:0]       aluResultM,
    input  logic [xlen-1:0]       dcacheDout,
    input  logic                  loadPendingM,
    output logic [xlen-1:0]       memForward,
    output logic [xlen-1:0]       wbData,
    output logic [regIdxBits-1:0] wbIdx,
    output logic                  wbEn
);

    // Load data arrives during M
    assign memForward = loadPendingM ? dcacheDout : aluResultM;

    // Destination and write flag into W
    always_ff @(posedge clk) begin
        if (reset) begin
            wbIdx <= '0;
            wbEn <= 1'b0;
        end else if (!stall) begin
            wbIdx <= instrM[11:7];
            // ALU, LUI and loads but never x0
            wbEn <= writesReg(instrM);
        end
    end

    // Write-back value
    always_ff @(posedge clk) begin
        if (!stall) begin
            wbData <= memForward;
        end
    end

endmodule

// ==== hw/riscvCore.sv ====
`timescale 1ns/100ps

module riscvCore import coreDefs::*; (
    input  logic            clk,
    input  logic            reset,
    input  logic            stall,
    input  logic [xlen-1:0] icacheDout,
    input  logic [xlen-1:0] dcacheDout,
    output logic [xlen-1:0] icacheAddr,
    output logic            icacheRe,
    output logic [xlen-1:0] dcacheAddr,
    output logic [3:0]      dcacheWe,
    output logic            dcacheRe,
    output logic [xlen-1:0] dcacheDin
);

    // FD to X
    logic [xlen-1:0] instrX;
    logic [xlen-1:0] pcX;
    logic [xlen-1:0] immX;
    logic [xlen-1:0] opAX;
    logic [xlen-1:0] opBX;
    // Redirect and forwarding back into FD
    logic flush;
    logic [xlen-1:0] branchTarget;
    logic [xlen-1:0] aluResultX;
    logic [xlen-1:0] memForward;
    // X to M
    logic [xlen-1:0] instrM;
    logic [xlen-1:0] aluResultM;
    logic loadPendingM;
    // Write-back port
    logic [xlen-1:0] wbData;
    logic [regIdxBits-1:0] wbIdx;
    logic wbEn;
    // Register reads
    logic [regIdxBits-1:0] rdIdxA;
    logic [regIdxBits-1:0] rdIdxB;
    logic [xlen-1:0] rdDataA;
    logic [xlen-1:0] rdDataB;

    fetchDecode fetchDecode_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .icacheDout(icacheDout),
        .flush(flush),
        .branchTarget(branchTarget),
        .aluResultX(aluResultX),
        .memForward(memForward),
        .wbData(wbData),
        .instrM(instrM),
        .wbIdx(wbIdx),
        .wbEn(wbEn),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB),
        .rdIdxA(rdIdxA),
        .rdIdxB(rdIdxB),
        .icacheAddr(icacheAddr),
        .icacheRe(icacheRe),
        .instrX(instrX),
        .pcX(pcX),
        .immX(immX),
        .opAX(opAX),
        .opBX(opBX)
    );

    regFile regFile_i (
        .clk(clk),
        .rdIdxA(rdIdxA),
        .rdIdxB(rdIdxB),
        .wrIdx(wbIdx),
        .wrData(wbData),
        .wrEn(wbEn),
        .rdDataA(rdDataA),
        .rdDataB(rdDataB)
    );

    executeStage executeStage_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .instrX(instrX),
        .pcX(pcX),
        .immX(immX),
        .opAX(opAX),
        .opBX(opBX),
        .aluResultX(aluResultX),
        .flush(flush),
        .branchTarget(branchTarget),
        .dcacheAddr(dcacheAddr),
        .dcacheWe(dcacheWe),
        .dcacheRe(dcacheRe),
        .dcacheDin(dcacheDin),
        .instrM(instrM),
        .aluResultM(aluResultM),
        .loadPendingM(loadPendingM)
    );

    memWriteback memWriteback_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .instrM(instrM),
        .aluResultM(aluResultM),
        .dcacheDout(dcacheDout),
        .loadPendingM(loadPendingM),
        .memForward(memForward),
        .wbData(wbData),
        .wbIdx(wbIdx),
        .wbEn(wbEn)
    );

endmodule

// ==== include/tbProgram.svh ====
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// RV32I encoders
function automatic logic [31:0] rType(input logic alt, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
    return {1'b0, alt, 5'b00000, rs2, rs1, f3, rd, opReg};
endfunction

function automatic logic [31:0] iType(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] sType(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], opStore};
endfunction

function automatic logic [31:0] bType(input logic [12:0] offset, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
    return {offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11], opBranch};
endfunction

function automatic logic [31:0] uType(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, opLui};
endfunction

// Random program at resetVector, then a NOP tail
task automatic buildProgram();
    logic [31:0] r;
    logic [4:0] rd;
    logic [2:0] f3;
    logic [11:0] imm;
    int n;
    int k;
    n = 0;
    // Defined values in x1 to x7 before any read
    for (k = 1; k < 8; k++) begin
        imem[n] = iType(12'(nextRandom()), 5'd0, 3'b000, 5'(k), opImm);
        n++;
    end
    while (n < progLen) begin
        r = nextRandom();
        rd = {2'b00, r[2:0]};
        f3 = r[11:9];
        // Word offsets 0 to 252 off x0
        imm = {4'b0000, r[21:16], 2'b00};
        case (r[15:12])
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6: begin
                imem[n] = rType(r[22] && (f3 == 3'b000 || f3 == 3'b101),
                                {2'b00, r[8:6]}, {2'b00, r[5:3]}, f3, rd);
            end
            4'd7, 4'd8, 4'd9: begin
                // Shifts keep the upper immediate bits legal
                if (f3 == 3'b001) begin
                    imm = {7'b0000000, r[20:16]};
                end else if (f3 == 3'b101) begin
                    imm = {1'b0, r[22], 5'b00000, r[20:16]};
                end else begin
                    imm = r[27:16];
                end
                imem[n] = iType(imm, {2'b00, r[5:3]}, f3, rd, opImm);
            end
            4'd10: imem[n] = uType(r[31:12], rd);
            4'd11: imem[n] = iType(imm, 5'd0, 3'b010, rd, opLoad);
            4'd12, 4'd13: imem[n] = sType(imm, {2'b00, r[8:6]}, 5'd0);
            4'd14: begin
                // Store of a value loaded just before it
                rd = (rd == 5'd0) ? 5'd1 : rd;
                if (n + 1 < progLen) begin
                    imem[n] = iType(imm, 5'd0, 3'b010, rd, opLoad);
                    n++;
                    imem[n] = sType({4'b0000, r[27:22], 2'b00}, rd, 5'd0);
                end else begin
                    imem[n] = nopInstr;
                end
            end
            default: begin
                // Skip 1 to 3 instructions forward
                imem[n] = bType(13'(8 + 4 * (r[17:16] % 3)), {2'b00, r[8:6]},
                                {2'b00, r[5:3]}, r[18] ? 3'b001 : 3'b000);
            end
        endcase
        n++;
    end
    for (k = progLen; k < imemWords; k++) begin
        imem[k] = nopInstr;
    end
endtask

// Sequential ISA model, records the store stream
task automatic runModel();
    logic [31:0] regs [0:31];
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] addr;
    logic isReg;
    int k;
    for (k = 0; k < 32; k++) begin
        regs[k] = '0;
    end
    for (k = 0; k < dmemWords; k++) begin
        modelMem[k] = fillWord(k);
    end
    storeCount = 0;
    pc = resetVector;
    // Forward branches only, so the walk ends
    while (pc < endAddr) begin
        instr = imem[(pc - resetVector) >> 2];
        isReg = (instr[6:0] == opReg);
        a = regs[instr[19:15]];
        b = isReg ? regs[instr[24:20]] : {{20{instr[31]}}, instr[31:20]};
        pc = pc + 32'd4;
        case (instr[6:0])
            opReg, opImm: begin
                case (instr[14:12])
                    3'b000: res = (isReg && instr[30]) ? a - b : a + b;
                    3'b001: res = a << b[4:0];
                    3'b010: res = {31'b0, $signed(a) < $signed(b)};
                    3'b011: res = {31'b0, a < b};
                    3'b100: res = a ^ b;
                    3'b101: begin
                        if (instr[30]) begin
                            res = $signed(a) >>> b[4:0];
                        end else begin
                            res = a >> b[4:0];
                        end
                    end
                    3'b110: res = a | b;
                    default: res = a & b;
                endcase
                regs[instr[11:7]] = res;
            end
            opLui: regs[instr[11:7]] = {instr[31:12], 12'b0};
            opLoad: begin
                addr = a + b;
                regs[instr[11:7]] = modelMem[addr[7:2]];
            end
            opStore: begin
                addr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
                expAddr[storeCount] = addr;
                expData[storeCount] = regs[instr[24:20]];
                modelMem[addr[7:2]] = regs[instr[24:20]];
                storeCount++;
            end
            opBranch: begin
                b = regs[instr[24:20]];
                if ((instr[14:12] == 3'b000 && a == b) || (instr[14:12] == 3'b001 && a != b)) begin
                    pc = pc - 32'd4 + {{19{instr[31]}}, instr[31], instr[7],
                                       instr[30:25], instr[11:8], 1'b0};
                end
            end
            default: ;
        endcase
        regs[0] = '0;
    end
endtask

`endif

// ==== verification/coreTb.sv ====
`timescale 1ns/100ps

module coreTb import coreDefs::*; ();

    localparam int progLen = 200;
    localparam int imemWords = 256;
    localparam int dmemWords = 64;
    // 200 instructions doubled for branches and for stall plus margin
    localparam int timeoutCycles = 1000;
    // Unstalled cycles for the last fetched instruction to clear X
    localparam int drainCycles = 4;
    localparam logic [31:0] seed = 32'h62119394;
    localparam logic [31:0] endAddr = resetVector + 4 * progLen;

    logic clk;
    logic reset;
    logic stall;
    logic [31:0] icacheDout;
    logic [31:0] dcacheDout;
    logic [31:0] icacheAddr;
    logic icacheRe;
    logic [31:0] dcacheAddr;
    logic [3:0] dcacheWe;
    logic dcacheRe;
    logic [31:0] dcacheDin;

    logic [31:0] rngState;
    logic stallOn;
    logic [31:0] imem [0:imemWords-1];
    logic [31:0] dmem [0:dmemWords-1];
    logic [31:0] modelMem [0:dmemWords-1];
    // Expected store stream from the model
    logic [31:0] expAddr [0:progLen-1];
    logic [31:0] expData [0:progLen-1];
    int storeCount;
    int storeIdx;
    // Read data waiting for the falling edge
    logic [31:0] iReadQ;
    logic [31:0] dReadQ;

    riscvCore riscvCore_i (
        .clk(clk),
        .reset(reset),
        .stall(stall),
        .icacheDout(icacheDout),
        .dcacheDout(dcacheDout),
        .icacheAddr(icacheAddr),
        .icacheRe(icacheRe),
        .dcacheAddr(dcacheAddr),
        .dcacheWe(dcacheWe),
        .dcacheRe(dcacheRe),
        .dcacheDin(dcacheDin)
    );

    // xorshift32
    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Initial data word built from every index bit
    function automatic logic [31:0] fillWord(input int idx);
        return {8'(idx) ^ 8'hC3, ~8'(idx), 8'(idx * 5), 8'(idx)};
    endfunction

    task automatic failRun();
        $display("Something failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic reportMismatch(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        failRun();
    endtask

    `include "tbProgram.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Both memories answer one cycle after the address and freeze under stall
    always @(posedge clk) begin
        if (!stall) begin
            iReadQ = imem[8'((icacheAddr - resetVector) >> 2)];
            // Data side reads only on a read enable
            if (dcacheRe) begin
                dReadQ = dmem[dcacheAddr[7:2]];
            end
            if (dcacheWe == 4'hF) begin
                dmem[dcacheAddr[7:2]] = dcacheDin;
                storeIdx++;
            end
        end
    end

    // All DUT inputs change on the falling edge
    always @(negedge clk) begin
        icacheDout = iReadQ;
        dcacheDout = dReadQ;
        // Roughly one cycle in four once reset is over
        if (stallOn) begin
            stall = ((nextRandom() & 32'h3) == 32'h0);
        end else begin
            stall = 1'b0;
        end
    end

    // Out of reset at the reset vector with no data access
    assert property (@(posedge clk) $fell(reset) |->
        (icacheAddr == resetVector) && (dcacheWe == 4'h0) && !dcacheRe)
        else reportMismatch("wrong fetch address or data access right after reset");

    // Store stream in model order with none extra
    assert property (@(posedge clk) disable iff (reset)
        ((dcacheWe == 4'hF) && !stall) |-> (storeIdx < storeCount) &&
        (dcacheAddr === expAddr[storeIdx]) && (dcacheDin === expData[storeIdx]))
        else reportMismatch($sformatf("store %0d wrote %h to %h, expected %h to %h",
            $sampled(storeIdx), $sampled(dcacheDin), $sampled(dcacheAddr),
            expData[$sampled(storeIdx)], expAddr[$sampled(storeIdx)]));

    // Outputs frozen for a stalled cycle
    assert property (@(posedge clk) disable iff (reset)
        stall |=> (icacheAddr === $past(icacheAddr)) && (dcacheAddr === $past(dcacheAddr)) &&
        (dcacheWe === $past(dcacheWe)) && (dcacheRe === $past(dcacheRe)) &&
        (dcacheDin === $past(dcacheDin)))
        else reportMismatch("core outputs changed while stalled");

    // Legal memory control on every cycle
    assert property (@(posedge clk) disable iff (reset)
        ((dcacheWe == 4'h0) || (dcacheWe == 4'hF)) && !(dcacheRe && (dcacheWe != 4'h0)) &&
        (icacheAddr[1:0] == 2'b00) && icacheRe)
        else reportMismatch($sformatf("bad memory control, we %b re %b fetch %h",
            $sampled(dcacheWe), $sampled(dcacheRe), $sampled(icacheAddr)));

    initial begin
        int cycles;
        cycles = 0;
        while (cycles < timeoutCycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the program did not finish within %0d cycles", timeoutCycles);
        failRun();
    end

    initial begin
        int k;
        int drained;
        reset = 1'b1;
        stall = 1'b0;
        stallOn = 1'b0;
        icacheDout = nopInstr;
        dcacheDout = '0;
        iReadQ = nopInstr;
        dReadQ = '0;
        storeIdx = 0;
        rngState = seed;
        buildProgram();
        runModel();
        for (k = 0; k < dmemWords; k++) begin
            dmem[k] = fillWord(k);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(posedge clk);
        stallOn = 1'b1;
        // Fetch has reached the NOP tail
        do begin
            @(posedge clk);
        end while (!((icacheAddr >= endAddr) && !stall));
        drained = 0;
        while (drained < drainCycles) begin
            @(posedge clk);
            if (!stall) begin
                drained++;
            end
        end
        @(negedge clk);
        if (storeIdx == storeCount) begin
            $display("Everything OK");
            $finish;
        end else begin
            reportMismatch($sformatf("%0d stores seen, %0d expected", storeIdx, storeCount));
        end
    end

endmodule

// ==== build.f ====
+incdir+include
hw/coreDefs.sv
hw/regFile.sv
hw/fetchDecode.sv
hw/executeStage.sv
hw/memWriteback.sv
hw/riscvCore.sv
verification/coreTb.sv
